// File: hw/dir_pkg.sv
`default_nettype none

package dir_pkg;

  // Physical address width, enough for the full system address space
  localparam int PADDR_BITS = 50;

  // Node id of the L2 that issued a request
  localparam int NID_BITS = 5;

  // Request id local to each L2, echoed back on its ack
  localparam int L2ID_BITS = 6;

  // Directory request id, the tag that travels to memory and back
  localparam int DRID_BITS = 6;

  // Request command and ack code widths
  localparam int CMD_BITS = 3;
  localparam int SNACK_BITS = 5;

  // One 64-byte cache line
  localparam int LINE_BITS = 512;

  // Number of drids this bank tracks
  localparam int DR_REQIDS = 16;

  // Index width needed to address one entry out of DR_REQIDS
  localparam int DR_IDX_BITS = $clog2(DR_REQIDS);

  typedef logic [PADDR_BITS-1:0] paddr_t;
  typedef logic [NID_BITS-1:0]   nid_t;
  typedef logic [L2ID_BITS-1:0]  l2id_t;
  typedef logic [DRID_BITS-1:0]  drid_t;
  typedef logic [CMD_BITS-1:0]   cmd_t;
  typedef logic [SNACK_BITS-1:0] snack_t;
  typedef logic [LINE_BITS-1:0]  line_t;

  // Drid 0 marks an ack that did not come from a snoop
  // The pool never hands it out, so at most DR_REQIDS-1 requests are in flight
  localparam drid_t DRID_NONE = '0;

endpackage

`default_nettype wire

// File: hw/id_table.sv
`timescale 1ns/1ps
`default_nettype none

module id_table (
  input  logic          clk,
  input  logic          we,
  input  dir_pkg::drid_t wdrid,
  input  dir_pkg::nid_t  wnid,
  input  dir_pkg::l2id_t wl2id,
  input  dir_pkg::drid_t rdrid,
  output dir_pkg::nid_t  rnid,
  output dir_pkg::l2id_t rl2id
);

  // One entry per drid, holding the requester that owns it
  dir_pkg::nid_t  nid_mem [dir_pkg::DR_REQIDS];
  dir_pkg::l2id_t l2id_mem [dir_pkg::DR_REQIDS];

  // Only the low bits address the array, since drids never exceed DR_REQIDS-1
  logic [dir_pkg::DR_IDX_BITS-1:0] widx;
  logic [dir_pkg::DR_IDX_BITS-1:0] ridx;

  assign widx = wdrid[dir_pkg::DR_IDX_BITS-1:0];
  assign ridx = rdrid[dir_pkg::DR_IDX_BITS-1:0];

  // Entry is filled on the edge that allocates its drid
  always_ff @(posedge clk) begin
    if (we) begin
      nid_mem[widx]  <= wnid;
      l2id_mem[widx] <= wl2id;
    end
  end

  // Lookup is combinational so the ack can be registered in the same cycle
  // it is accepted
  assign rnid  = nid_mem[ridx];
  assign rl2id = l2id_mem[ridx];

endmodule

`default_nettype wire

// File: hw/drid_pool.sv
`timescale 1ns/1ps
`default_nettype none

module drid_pool (
  input  logic           clk,
  input  logic           rst,
  input  logic           alloc,
  input  logic           release_en,
  input  dir_pkg::drid_t release_drid,
  output logic           free_valid,
  output dir_pkg::drid_t free_drid
);

  // A set bit means the drid at that index is available
  logic [dir_pkg::DR_REQIDS-1:0] free_q;
  logic [dir_pkg::DR_REQIDS-1:0] free_next;

  // Priority encoder, lowest free index above zero wins
  // The loop runs downward so the last hit is the smallest one
  always_comb begin
    free_valid = 1'b0;
    free_drid  = dir_pkg::DRID_NONE;
    for (int i = dir_pkg::DR_REQIDS - 1; i >= 1; i--) begin
      if (free_q[i]) begin
        free_valid = 1'b1;
        free_drid  = dir_pkg::drid_t'(i);
      end
    end
  end

  // Allocation and release touch different drids, so both may land together
  // A released drid is outstanding and can never be the one being allocated
  always_comb begin
    free_next = free_q;
    if (alloc) begin
      free_next[free_drid[dir_pkg::DR_IDX_BITS-1:0]] = 1'b0;
    end
    if (release_en) begin
      free_next[release_drid[dir_pkg::DR_IDX_BITS-1:0]] = 1'b1;
    end
    // Drid 0 stays reserved whatever happens above
    free_next[0] = 1'b0;
  end

  // Out of reset everything except drid 0 is free
  always_ff @(posedge clk) begin
    if (rst) begin
      free_q <= {{(dir_pkg::DR_REQIDS - 1){1'b1}}, 1'b0};
    end else begin
      free_q <= free_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/dir_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dir_ctrl (
  input  logic            clk,
  input  logic            rst,

  // Requests from the L2s
  input  logic            l2todr_req_valid,
  output logic            l2todr_req_retry,
  input  dir_pkg::nid_t   l2todr_req_nid,
  input  dir_pkg::l2id_t  l2todr_req_l2id,
  input  dir_pkg::paddr_t l2todr_req_paddr,
  input  dir_pkg::cmd_t   l2todr_req_cmd,

  // Requests toward memory, tagged with a drid
  output logic            drtomem_req_valid,
  input  logic            drtomem_req_retry,
  output dir_pkg::paddr_t drtomem_req_paddr,
  output dir_pkg::cmd_t   drtomem_req_cmd,
  output dir_pkg::drid_t  drtomem_req_drid,

  // Acks from memory, possibly out of order
  input  logic            memtodr_ack_valid,
  output logic            memtodr_ack_retry,
  input  dir_pkg::drid_t  memtodr_ack_drid,
  input  dir_pkg::snack_t memtodr_ack_snack,
  input  dir_pkg::line_t  memtodr_ack_line,

  // Acks back to the requesting L2
  output logic            drtol2_snack_valid,
  input  logic            drtol2_snack_retry,
  output dir_pkg::nid_t   drtol2_snack_nid,
  output dir_pkg::l2id_t  drtol2_snack_l2id,
  output dir_pkg::snack_t drtol2_snack_snack,
  output dir_pkg::line_t  drtol2_snack_line,
  output dir_pkg::drid_t  drtol2_snack_drid,

  // Displacements from the L2s
  input  logic            l2todr_disp_valid,
  output logic            l2todr_disp_retry,
  input  dir_pkg::nid_t   l2todr_disp_nid,
  input  dir_pkg::l2id_t  l2todr_disp_l2id,
  input  dir_pkg::paddr_t l2todr_disp_paddr,
  input  dir_pkg::line_t  l2todr_disp_line,

  // Writebacks toward memory
  output logic            drtomem_wb_valid,
  input  logic            drtomem_wb_retry,
  output dir_pkg::paddr_t drtomem_wb_paddr,
  output dir_pkg::line_t  drtomem_wb_line,

  // Displacement acks back to the L2
  output logic            drtol2_dack_valid,
  input  logic            drtol2_dack_retry,
  output dir_pkg::nid_t   drtol2_dack_nid,
  output dir_pkg::l2id_t  drtol2_dack_l2id,

  // Drid pool
  output logic            alloc,
  output logic            release_en,
  output dir_pkg::drid_t  release_drid,
  input  logic            free_valid,
  input  dir_pkg::drid_t  free_drid,

  // Id table
  output logic            tbl_we,
  output dir_pkg::drid_t  tbl_wdrid,
  output dir_pkg::nid_t   tbl_wnid,
  output dir_pkg::l2id_t  tbl_wl2id,
  output dir_pkg::drid_t  tbl_rdrid,
  input  dir_pkg::nid_t   tbl_rnid,
  input  dir_pkg::l2id_t  tbl_rl2id
);

  logic req_accept;
  logic ack_accept;
  logic disp_accept;

  // A request forks into a drid allocation and a memory request
  // Both halves must be able to go, so a full memory register that is not
  // draining or an empty pool stalls the L2
  assign l2todr_req_retry = (drtomem_req_valid && drtomem_req_retry) || !free_valid;
  assign req_accept       = l2todr_req_valid && !l2todr_req_retry;

  // Allocate and record the requester on the accepting edge
  assign alloc     = req_accept;
  assign tbl_we    = req_accept;
  assign tbl_wdrid = free_drid;
  assign tbl_wnid  = l2todr_req_nid;
  assign tbl_wl2id = l2todr_req_l2id;

  // The ack only waits when the snack register is full and blocked
  assign memtodr_ack_retry = drtol2_snack_valid && drtol2_snack_retry;
  assign ack_accept        = memtodr_ack_valid && !memtodr_ack_retry;

  // Look up the owner of the acked drid and hand the drid back
  assign tbl_rdrid    = memtodr_ack_drid;
  assign release_en   = ack_accept;
  assign release_drid = memtodr_ack_drid;

  // Snack toward the L2 never carries a snoop drid in passthrough
  assign drtol2_snack_drid = dir_pkg::DRID_NONE;

  // A displacement needs room in both the writeback and the dack register,
  // since it loads them together
  assign l2todr_disp_retry = (drtomem_wb_valid && drtomem_wb_retry) ||
                             (drtol2_dack_valid && drtol2_dack_retry);
  assign disp_accept       = l2todr_disp_valid && !l2todr_disp_retry;

  // Memory request register, joins the L2 request with its new drid
  always_ff @(posedge clk) begin
    if (rst) begin
      drtomem_req_valid <= 1'b0;
    end else if (req_accept) begin
      drtomem_req_valid <= 1'b1;
    end else if (!drtomem_req_retry) begin
      drtomem_req_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_accept) begin
      drtomem_req_paddr <= l2todr_req_paddr;
      drtomem_req_cmd   <= l2todr_req_cmd;
      drtomem_req_drid  <= free_drid;
    end
  end

  // Snack register, built from the memory ack and the looked-up ids
  always_ff @(posedge clk) begin
    if (rst) begin
      drtol2_snack_valid <= 1'b0;
    end else if (ack_accept) begin
      drtol2_snack_valid <= 1'b1;
    end else if (!drtol2_snack_retry) begin
      drtol2_snack_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ack_accept) begin
      drtol2_snack_nid   <= tbl_rnid;
      drtol2_snack_l2id  <= tbl_rl2id;
      drtol2_snack_snack <= memtodr_ack_snack;
      drtol2_snack_line  <= memtodr_ack_line;
    end
  end

  // Writeback and dack rise together but drain on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      drtomem_wb_valid <= 1'b0;
    end else if (disp_accept) begin
      drtomem_wb_valid <= 1'b1;
    end else if (!drtomem_wb_retry) begin
      drtomem_wb_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drtol2_dack_valid <= 1'b0;
    end else if (disp_accept) begin
      drtol2_dack_valid <= 1'b1;
    end else if (!drtol2_dack_retry) begin
      drtol2_dack_valid <= 1'b0;
    end
  end

  // Displacement payload splits into the plain writeback and the ack ids
  always_ff @(posedge clk) begin
    if (disp_accept) begin
      drtomem_wb_paddr <= l2todr_disp_paddr;
      drtomem_wb_line  <= l2todr_disp_line;
      drtol2_dack_nid  <= l2todr_disp_nid;
      drtol2_dack_l2id <= l2todr_disp_l2id;
    end
  end

endmodule

`default_nettype wire

// File: hw/dir_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dir_bank (
  input  logic            clk,
  input  logic            rst,

  // L2 side
  input  logic            l2todr_req_valid,
  output logic            l2todr_req_retry,
  input  dir_pkg::nid_t   l2todr_req_nid,
  input  dir_pkg::l2id_t  l2todr_req_l2id,
  input  dir_pkg::paddr_t l2todr_req_paddr,
  input  dir_pkg::cmd_t   l2todr_req_cmd,

  output logic            drtol2_snack_valid,
  input  logic            drtol2_snack_retry,
  output dir_pkg::nid_t   drtol2_snack_nid,
  output dir_pkg::l2id_t  drtol2_snack_l2id,
  output dir_pkg::snack_t drtol2_snack_snack,
  output dir_pkg::line_t  drtol2_snack_line,
  output dir_pkg::drid_t  drtol2_snack_drid,

  input  logic            l2todr_disp_valid,
  output logic            l2todr_disp_retry,
  input  dir_pkg::nid_t   l2todr_disp_nid,
  input  dir_pkg::l2id_t  l2todr_disp_l2id,
  input  dir_pkg::paddr_t l2todr_disp_paddr,
  input  dir_pkg::line_t  l2todr_disp_line,

  output logic            drtol2_dack_valid,
  input  logic            drtol2_dack_retry,
  output dir_pkg::nid_t   drtol2_dack_nid,
  output dir_pkg::l2id_t  drtol2_dack_l2id,

  // Memory side
  output logic            drtomem_req_valid,
  input  logic            drtomem_req_retry,
  output dir_pkg::paddr_t drtomem_req_paddr,
  output dir_pkg::cmd_t   drtomem_req_cmd,
  output dir_pkg::drid_t  drtomem_req_drid,

  input  logic            memtodr_ack_valid,
  output logic            memtodr_ack_retry,
  input  dir_pkg::drid_t  memtodr_ack_drid,
  input  dir_pkg::snack_t memtodr_ack_snack,
  input  dir_pkg::line_t  memtodr_ack_line,

  output logic            drtomem_wb_valid,
  input  logic            drtomem_wb_retry,
  output dir_pkg::paddr_t drtomem_wb_paddr,
  output dir_pkg::line_t  drtomem_wb_line
);

  // Pool handshake
  logic           alloc;
  logic           release_en;
  dir_pkg::drid_t release_drid;
  logic           free_valid;
  dir_pkg::drid_t free_drid;

  // Table ports
  logic           tbl_we;
  dir_pkg::drid_t tbl_wdrid;
  dir_pkg::nid_t  tbl_wnid;
  dir_pkg::l2id_t tbl_wl2id;
  dir_pkg::drid_t tbl_rdrid;
  dir_pkg::nid_t  tbl_rnid;
  dir_pkg::l2id_t tbl_rl2id;

  // All channel handshakes and output registers live in the controller
  dir_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .l2todr_req_valid   (l2todr_req_valid),
    .l2todr_req_retry   (l2todr_req_retry),
    .l2todr_req_nid     (l2todr_req_nid),
    .l2todr_req_l2id    (l2todr_req_l2id),
    .l2todr_req_paddr   (l2todr_req_paddr),
    .l2todr_req_cmd     (l2todr_req_cmd),
    .drtomem_req_valid  (drtomem_req_valid),
    .drtomem_req_retry  (drtomem_req_retry),
    .drtomem_req_paddr  (drtomem_req_paddr),
    .drtomem_req_cmd    (drtomem_req_cmd),
    .drtomem_req_drid   (drtomem_req_drid),
    .memtodr_ack_valid  (memtodr_ack_valid),
    .memtodr_ack_retry  (memtodr_ack_retry),
    .memtodr_ack_drid   (memtodr_ack_drid),
    .memtodr_ack_snack  (memtodr_ack_snack),
    .memtodr_ack_line   (memtodr_ack_line),
    .drtol2_snack_valid (drtol2_snack_valid),
    .drtol2_snack_retry (drtol2_snack_retry),
    .drtol2_snack_nid   (drtol2_snack_nid),
    .drtol2_snack_l2id  (drtol2_snack_l2id),
    .drtol2_snack_snack (drtol2_snack_snack),
    .drtol2_snack_line  (drtol2_snack_line),
    .drtol2_snack_drid  (drtol2_snack_drid),
    .l2todr_disp_valid  (l2todr_disp_valid),
    .l2todr_disp_retry  (l2todr_disp_retry),
    .l2todr_disp_nid    (l2todr_disp_nid),
    .l2todr_disp_l2id   (l2todr_disp_l2id),
    .l2todr_disp_paddr  (l2todr_disp_paddr),
    .l2todr_disp_line   (l2todr_disp_line),
    .drtomem_wb_valid   (drtomem_wb_valid),
    .drtomem_wb_retry   (drtomem_wb_retry),
    .drtomem_wb_paddr   (drtomem_wb_paddr),
    .drtomem_wb_line    (drtomem_wb_line),
    .drtol2_dack_valid  (drtol2_dack_valid),
    .drtol2_dack_retry  (drtol2_dack_retry),
    .drtol2_dack_nid    (drtol2_dack_nid),
    .drtol2_dack_l2id   (drtol2_dack_l2id),
    .alloc              (alloc),
    .release_en         (release_en),
    .release_drid       (release_drid),
    .free_valid         (free_valid),
    .free_drid          (free_drid),
    .tbl_we             (tbl_we),
    .tbl_wdrid          (tbl_wdrid),
    .tbl_wnid           (tbl_wnid),
    .tbl_wl2id          (tbl_wl2id),
    .tbl_rdrid          (tbl_rdrid),
    .tbl_rnid           (tbl_rnid),
    .tbl_rl2id          (tbl_rl2id)
  );

  drid_pool u_pool (
    .clk          (clk),
    .rst          (rst),
    .alloc        (alloc),
    .release_en   (release_en),
    .release_drid (release_drid),
    .free_valid   (free_valid),
    .free_drid    (free_drid)
  );

  // Maps each outstanding drid back to its requester
  id_table u_table (
    .clk   (clk),
    .we    (tbl_we),
    .wdrid (tbl_wdrid),
    .wnid  (tbl_wnid),
    .wl2id (tbl_wl2id),
    .rdrid (tbl_rdrid),
    .rnid  (tbl_rnid),
    .rl2id (tbl_rl2id)
  );

endmodule

`default_nettype wire

// File: testbench/tb_dir_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dir_bank;

  typedef logic [dir_pkg::LINE_BITS-1:0] word_t;

  localparam int ENTRIES     = 24;
  localparam int CYCLE_LIMIT = 300 * ENTRIES;
  localparam int DRID_SPACE  = 1 << dir_pkg::DRID_BITS;
  localparam int KIND_REQ    = 0;
  localparam int KIND_DISP   = 1;

  logic clk = 1'b0;
  logic rst;

  logic            l2todr_req_valid, l2todr_req_retry;
  dir_pkg::nid_t   l2todr_req_nid;
  dir_pkg::l2id_t  l2todr_req_l2id;
  dir_pkg::paddr_t l2todr_req_paddr;
  dir_pkg::cmd_t   l2todr_req_cmd;
  logic            drtol2_snack_valid, drtol2_snack_retry;
  dir_pkg::nid_t   drtol2_snack_nid;
  dir_pkg::l2id_t  drtol2_snack_l2id;
  dir_pkg::snack_t drtol2_snack_snack;
  dir_pkg::line_t  drtol2_snack_line;
  dir_pkg::drid_t  drtol2_snack_drid;
  logic            l2todr_disp_valid, l2todr_disp_retry;
  dir_pkg::nid_t   l2todr_disp_nid;
  dir_pkg::l2id_t  l2todr_disp_l2id;
  dir_pkg::paddr_t l2todr_disp_paddr;
  dir_pkg::line_t  l2todr_disp_line;
  logic            drtol2_dack_valid, drtol2_dack_retry;
  dir_pkg::nid_t   drtol2_dack_nid;
  dir_pkg::l2id_t  drtol2_dack_l2id;
  logic            drtomem_req_valid, drtomem_req_retry;
  dir_pkg::paddr_t drtomem_req_paddr;
  dir_pkg::cmd_t   drtomem_req_cmd;
  dir_pkg::drid_t  drtomem_req_drid;
  logic            memtodr_ack_valid, memtodr_ack_retry;
  dir_pkg::drid_t  memtodr_ack_drid;
  dir_pkg::snack_t memtodr_ack_snack;
  dir_pkg::line_t  memtodr_ack_line;
  logic            drtomem_wb_valid, drtomem_wb_retry;
  dir_pkg::paddr_t drtomem_wb_paddr;
  dir_pkg::line_t  drtomem_wb_line;

  // Stimulus table with one row per L2 transaction
  int              tab_kind  [ENTRIES];
  dir_pkg::nid_t   tab_nid   [ENTRIES];
  dir_pkg::l2id_t  tab_l2id  [ENTRIES];
  dir_pkg::paddr_t tab_paddr [ENTRIES];
  dir_pkg::cmd_t   tab_cmd   [ENTRIES];
  dir_pkg::line_t  tab_line  [ENTRIES];
  int              tab_delay [ENTRIES];
  int              tab_reqs, tab_disps;

  // Memory model state indexed by drid
  logic out_busy  [DRID_SPACE];
  logic out_sent  [DRID_SPACE];
  logic out_acked [DRID_SPACE];
  int   out_entry [DRID_SPACE];
  int   out_due   [DRID_SPACE];

  // Controls the main sequence hands to the per-cycle driver
  logic req_pend, disp_pend, mem_hold, snack_hold, rand_retry;
  int   req_idx, disp_idx;

  // Handshakes as they stood just before the last rising edge
  logic req_acc, ack_acc, disp_acc, mreq_xfer, snack_xfer, wb_xfer, dack_xfer;
  int   req_idx_acc, disp_idx_acc, ack_drid_acc, mreq_drid_acc;

  // Table rows whose data the output registers must hold
  int mreq_entry, snack_entry, disp_entry;

  int n_checks, n_errors, cycle;
  int n_req_acc, n_disp_acc, n_acks, n_mreq_xfer, n_snack_xfer, n_wb_xfer, n_dack_xfer;

  // Port names match one to one
  dir_bank dut (.*);

  always #5 clk = ~clk;

  // Cycle count is advanced on the falling edge and looked at on the rising one
  always @(posedge clk) begin
    if (cycle > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the bank stopped making progress", cycle);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(string name, word_t act, word_t exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s: got %0h, expected %0h", name, act, exp);
    end
  endtask

  // Memory fills a line with the request address repeated from bit 0 up
  function automatic dir_pkg::line_t repeat_line(dir_pkg::paddr_t p);
    dir_pkg::line_t l;
    for (int b = 0; b < dir_pkg::LINE_BITS; b++) begin
      l[b] = p[b % dir_pkg::PADDR_BITS];
    end
    return l;
  endfunction

  // First 16 rows are requests, later even rows are displacements
  task automatic build_table();
    tab_reqs  = 0;
    tab_disps = 0;
    for (int i = 0; i < ENTRIES; i++) begin
      tab_kind[i]  = (i >= 16 && i % 2 == 0) ? KIND_DISP : KIND_REQ;
      tab_nid[i]   = dir_pkg::nid_t'($urandom);
      tab_l2id[i]  = dir_pkg::l2id_t'(i);
      tab_paddr[i] = dir_pkg::paddr_t'({$urandom, $urandom});
      tab_cmd[i]   = dir_pkg::cmd_t'($urandom);
      for (int w = 0; w < dir_pkg::LINE_BITS / 32; w++) begin
        tab_line[i][w*32 +: 32] = $urandom;
      end
      tab_delay[i] = int'(1 + $urandom % 40);
      if (tab_kind[i] == KIND_REQ) tab_reqs++;
      else tab_disps++;
    end
  endtask

  // Check what the last rising edge produced
  task automatic observe();
    int e;
    int d;
    if (req_acc) begin
      e = req_idx_acc;
      d = int'(drtomem_req_drid);
      n_req_acc++;
      mreq_entry = e;
      check_value("drtomem_req_valid", word_t'(drtomem_req_valid), word_t'(1'b1));
      check_value("drtomem_req_drid nonzero",
                  word_t'(drtomem_req_drid != dir_pkg::DRID_NONE), word_t'(1'b1));
      check_value("drtomem_req_drid outstanding", word_t'(out_busy[d]), word_t'(1'b0));
      // The drid is in flight from here on, though memory sees it only once it transfers
      out_busy[d]  = 1'b1;
      out_sent[d]  = 1'b0;
      out_acked[d] = 1'b0;
      out_entry[d] = e;
    end
    // A held memory request keeps the data of the last request taken
    if (drtomem_req_valid && mreq_entry >= 0) begin
      e = mreq_entry;
      check_value("drtomem_req_paddr", word_t'(drtomem_req_paddr), word_t'(tab_paddr[e]));
      check_value("drtomem_req_cmd", word_t'(drtomem_req_cmd), word_t'(tab_cmd[e]));
    end
    // Memory starts counting its delay when the request reaches it
    if (mreq_xfer) begin
      n_mreq_xfer++;
      out_sent[mreq_drid_acc] = 1'b1;
      out_due[mreq_drid_acc]  = cycle + tab_delay[out_entry[mreq_drid_acc]];
    end
    if (ack_acc) begin
      n_acks++;
      check_value("drtol2_snack_valid", word_t'(drtol2_snack_valid), word_t'(1'b1));
      snack_entry = out_entry[ack_drid_acc];
      out_busy[ack_drid_acc] = 1'b0;
      memtodr_ack_valid = 1'b0;
    end
    // A held snack keeps the data of the last ack taken
    if (drtol2_snack_valid && snack_entry >= 0) begin
      e = snack_entry;
      check_value("drtol2_snack_nid", word_t'(drtol2_snack_nid), word_t'(tab_nid[e]));
      check_value("drtol2_snack_l2id", word_t'(drtol2_snack_l2id), word_t'(tab_l2id[e]));
      check_value("drtol2_snack_snack", word_t'(drtol2_snack_snack),
                  word_t'(dir_pkg::snack_t'(tab_cmd[e])));
      check_value("drtol2_snack_line", drtol2_snack_line, repeat_line(tab_paddr[e]));
      check_value("drtol2_snack_drid", word_t'(drtol2_snack_drid), word_t'(dir_pkg::DRID_NONE));
    end
    if (disp_acc) begin
      n_disp_acc++;
      disp_entry = disp_idx_acc;
      check_value("drtomem_wb_valid", word_t'(drtomem_wb_valid), word_t'(1'b1));
      check_value("drtol2_dack_valid", word_t'(drtol2_dack_valid), word_t'(1'b1));
    end
    if (drtomem_wb_valid && disp_entry >= 0) begin
      check_value("drtomem_wb_paddr", word_t'(drtomem_wb_paddr), word_t'(tab_paddr[disp_entry]));
      check_value("drtomem_wb_line", drtomem_wb_line, tab_line[disp_entry]);
    end
    if (drtol2_dack_valid && disp_entry >= 0) begin
      check_value("drtol2_dack_nid", word_t'(drtol2_dack_nid), word_t'(tab_nid[disp_entry]));
      check_value("drtol2_dack_l2id", word_t'(drtol2_dack_l2id), word_t'(tab_l2id[disp_entry]));
    end
    if (snack_xfer) n_snack_xfer++;
    if (wb_xfer) n_wb_xfer++;
    if (dack_xfer) n_dack_xfer++;
  endtask

  task automatic drive();
    int best;
    l2todr_req_valid = req_pend;
    if (req_pend) begin
      l2todr_req_nid   = tab_nid[req_idx];
      l2todr_req_l2id  = tab_l2id[req_idx];
      l2todr_req_paddr = tab_paddr[req_idx];
      l2todr_req_cmd   = tab_cmd[req_idx];
    end
    l2todr_disp_valid = disp_pend;
    if (disp_pend) begin
      l2todr_disp_nid   = tab_nid[disp_idx];
      l2todr_disp_l2id  = tab_l2id[disp_idx];
      l2todr_disp_paddr = tab_paddr[disp_idx];
      l2todr_disp_line  = tab_line[disp_idx];
    end
    drtomem_req_retry  = rand_retry && ($urandom % 3 == 0);
    drtol2_snack_retry = snack_hold || (rand_retry && ($urandom % 3 == 0));
    drtomem_wb_retry   = rand_retry && ($urandom % 3 == 0);
    drtol2_dack_retry  = rand_retry && ($urandom % 3 == 0);
    // Memory answers the due drid with the earliest deadline, not the oldest one
    // A presented ack stays put until the bank takes it
    if (!memtodr_ack_valid && !mem_hold) begin
      best = -1;
      for (int d = 1; d < DRID_SPACE; d++) begin
        if (out_busy[d] && out_sent[d] && !out_acked[d] && out_due[d] <= cycle &&
            (best < 0 || out_due[d] < out_due[best])) begin
          best = d;
        end
      end
      if (best >= 0) begin
        out_acked[best]   = 1'b1;
        memtodr_ack_valid = 1'b1;
        memtodr_ack_drid  = dir_pkg::drid_t'(best);
        memtodr_ack_snack = dir_pkg::snack_t'(tab_cmd[out_entry[best]]);
        memtodr_ack_line  = repeat_line(tab_paddr[out_entry[best]]);
      end
    end
  endtask

  // Inputs and retries are settled here and hold until the rising edge
  task automatic record();
    req_acc       = l2todr_req_valid && !l2todr_req_retry;
    req_idx_acc   = req_idx;
    disp_acc      = l2todr_disp_valid && !l2todr_disp_retry;
    disp_idx_acc  = disp_idx;
    ack_acc       = memtodr_ack_valid && !memtodr_ack_retry;
    ack_drid_acc  = int'(memtodr_ack_drid);
    mreq_xfer     = drtomem_req_valid && !drtomem_req_retry;
    mreq_drid_acc = int'(drtomem_req_drid);
    snack_xfer    = drtol2_snack_valid && !drtol2_snack_retry;
    wb_xfer       = drtomem_wb_valid && !drtomem_wb_retry;
    dack_xfer     = drtol2_dack_valid && !drtol2_dack_retry;
    if (req_acc) req_pend = 1'b0;
    if (disp_acc) disp_pend = 1'b0;
  endtask

  // One clock cycle with everything handled on the falling edge
  task automatic step();
    @(negedge clk);
    cycle++;
    observe();
    drive();
    #1;
    record();
  endtask

  task automatic send_entry(int i);
    if (tab_kind[i] == KIND_REQ) begin
      req_idx  = i;
      req_pend = 1'b1;
      while (req_pend) step();
    end else begin
      disp_idx  = i;
      disp_pend = 1'b1;
      while (disp_pend) step();
    end
  endtask

  initial begin
    void'($urandom(89));
    rst = 1'b1;
    l2todr_req_valid   = 1'b0;
    l2todr_req_nid     = '0;
    l2todr_req_l2id    = '0;
    l2todr_req_paddr   = '0;
    l2todr_req_cmd     = '0;
    l2todr_disp_valid  = 1'b0;
    l2todr_disp_nid    = '0;
    l2todr_disp_l2id   = '0;
    l2todr_disp_paddr  = '0;
    l2todr_disp_line   = '0;
    memtodr_ack_valid  = 1'b0;
    memtodr_ack_drid   = '0;
    memtodr_ack_snack  = '0;
    memtodr_ack_line   = '0;
    drtomem_req_retry  = 1'b0;
    drtol2_snack_retry = 1'b0;
    drtomem_wb_retry   = 1'b0;
    drtol2_dack_retry  = 1'b0;
    for (int d = 0; d < DRID_SPACE; d++) begin
      out_busy[d]  = 1'b0;
      out_sent[d]  = 1'b0;
      out_acked[d] = 1'b0;
      out_entry[d] = 0;
      out_due[d]   = 0;
    end
    {req_pend, disp_pend, mem_hold, snack_hold, rand_retry} = '0;
    {req_acc, ack_acc, disp_acc, mreq_xfer, snack_xfer, wb_xfer, dack_xfer} = '0;
    req_idx = 0;
    disp_idx = 0;
    mreq_entry = -1;
    snack_entry = -1;
    disp_entry = -1;
    {n_checks, n_errors, cycle} = '0;
    {n_req_acc, n_disp_acc, n_acks, n_mreq_xfer} = '0;
    {n_snack_xfer, n_wb_xfer, n_dack_xfer} = '0;
    build_table();
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Idle bank offers nothing and has the whole pool free
    repeat (2) step();
    check_value("drtomem_req_valid", word_t'(drtomem_req_valid), word_t'(1'b0));
    check_value("drtol2_snack_valid", word_t'(drtol2_snack_valid), word_t'(1'b0));
    check_value("drtomem_wb_valid", word_t'(drtomem_wb_valid), word_t'(1'b0));
    check_value("drtol2_dack_valid", word_t'(drtol2_dack_valid), word_t'(1'b0));
    check_value("l2todr_req_retry", word_t'(l2todr_req_retry), word_t'(1'b0));

    // Memory sits on every ack, so 15 requests use up the pool
    mem_hold   = 1'b1;
    snack_hold = 1'b1;
    for (int i = 0; i < dir_pkg::DR_REQIDS - 1; i++) send_entry(i);
    req_idx  = dir_pkg::DR_REQIDS - 1;
    req_pend = 1'b1;
    repeat (20) step();
    check_value("l2todr_req_retry", word_t'(l2todr_req_retry), word_t'(1'b1));
    check_value("requests in flight", word_t'(n_req_acc), word_t'(dir_pkg::DR_REQIDS - 1));
    mem_hold = 1'b0;
    while (req_pend) step();
    check_value("acks before 16th request", word_t'(n_acks > 0), word_t'(1'b1));

    // The snack register stays blocked, so the next ack gets pushed back
    while (!memtodr_ack_valid) step();
    repeat (3) step();
    check_value("memtodr_ack_retry", word_t'(memtodr_ack_retry), word_t'(1'b1));
    check_value("acks taken while blocked", word_t'(n_acks), word_t'(1));

    // Remaining rows mix requests and displacements under random back-pressure
    snack_hold = 1'b0;
    rand_retry = 1'b1;
    for (int i = dir_pkg::DR_REQIDS; i < ENTRIES; i++) send_entry(i);
    while (n_snack_xfer < tab_reqs || n_wb_xfer < tab_disps || n_dack_xfer < tab_disps) begin
      step();
    end
    rand_retry = 1'b0;
    // Quiet tail catches any output that shows up twice
    repeat (20) step();
    check_value("requests accepted", word_t'(n_req_acc), word_t'(tab_reqs));
    check_value("drtomem_req transfers", word_t'(n_mreq_xfer), word_t'(tab_reqs));
    check_value("memtodr acks taken", word_t'(n_acks), word_t'(tab_reqs));
    check_value("drtol2_snack transfers", word_t'(n_snack_xfer), word_t'(tab_reqs));
    check_value("displacements accepted", word_t'(n_disp_acc), word_t'(tab_disps));
    check_value("drtomem_wb transfers", word_t'(n_wb_xfer), word_t'(tab_disps));
    check_value("drtol2_dack transfers", word_t'(n_dack_xfer), word_t'(tab_disps));

    $display("Checks run: %0d, errors: %0d, cycles: %0d", n_checks, n_errors, cycle);
    if (n_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hw/dir_pkg.sv
hw/id_table.sv
hw/drid_pool.sv
hw/dir_ctrl.sv
hw/dir_bank.sv
testbench/tb_dir_bank.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message
rm -rf obj_dir sim.log
{ verilator --binary --timing --top-module tb_dir_bank -f verilog.f -o sim_dir_bank &&
  ./obj_dir/sim_dir_bank; } > sim.log 2>&1 ||
  echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && echo "RESULT: FAIL" && exit 1 ||
  echo "RESULT: PASS"
